// ==== Makefile ====
SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= stream_pipe_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Something failed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	set -o pipefail; ./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	else \
		echo "No failure reported in $(LOG)"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
src/stream_pkg.sv
src/skid_buffer.sv
src/scale_stage.sv
src/pipe_ctrl.sv
src/stream_pipe_top.sv
verif/stream_pipe_props.sv
verif/stream_pipe_tb.sv

// ==== src/pipe_ctrl.sv ====
`timescale 1ns/1ps

// Sequences the flush, keeps the in-flight count and counts delivered frames
module pipe_ctrl (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     flush_i,
   input  logic                     in_fire_i,
   input  logic                     out_fire_i,
   input  logic                     out_last_i,
   output logic                     flush_o,
   output logic                     accept_o,
   output logic                     busy_o,
   output stream_pkg::frame_count_t frame_count_o
);

   // Two beats per skid buffer plus one in the scaling stage
   localparam int unsigned OCC_MAX = 5;
   localparam int unsigned OCC_W   = $clog2(OCC_MAX + 1);

   stream_pkg::ctrl_state_t  state_q;
   logic [OCC_W-1:0]         occ_q;
   stream_pkg::frame_count_t frames_q;

   assign flush_o       = (state_q == stream_pkg::CTRL_FLUSH);
   // Input stays closed for the flush cycle and the drain cycle after it
   assign accept_o      = (state_q == stream_pkg::CTRL_RUN);
   assign busy_o        = (occ_q != '0);
   assign frame_count_o = frames_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= stream_pkg::CTRL_RUN;
      end else begin
         case (state_q)
            stream_pkg::CTRL_RUN: begin
               if (flush_i) begin
                  state_q <= stream_pkg::CTRL_FLUSH;
               end
            end
            stream_pkg::CTRL_FLUSH: begin
               state_q <= stream_pkg::CTRL_DRAIN;
            end
            default: begin
               state_q <= stream_pkg::CTRL_RUN;
            end
         endcase
      end
   end

   // The stages are empty once the flush pulse has passed, so the count restarts at zero
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         occ_q <= '0;
      end else if (state_q != stream_pkg::CTRL_RUN) begin
         occ_q <= '0;
      end else begin
         case ({in_fire_i, out_fire_i})
            2'b10:   occ_q <= occ_q + 1'b1;
            2'b01:   occ_q <= occ_q - 1'b1;
            default: occ_q <= occ_q;
         endcase
      end
   end

   // Frames keep counting across flushes
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         frames_q <= '0;
      end else if (out_fire_i && out_last_i) begin
         frames_q <= frames_q + 1'b1;
      end
   end

endmodule

// ==== src/scale_stage.sv ====
`timescale 1ns/1ps

// Single register stage that applies gain, shift, offset and saturation
module scale_stage #(
   parameter int unsigned FRAC_W = 8
) (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                flush_i,

   input  stream_pkg::gain_t   gain_i,
   input  stream_pkg::sample_t offset_i,

   input  logic                in_valid_i,
   output logic                in_ready_o,
   input  stream_pkg::beat_t   in_beat_i,

   output logic                out_valid_o,
   input  logic                out_ready_i,
   output stream_pkg::beat_t   out_beat_o
);

   // Limits of the sample range, expressed at product width
   localparam stream_pkg::prod_t SAT_MAX = 32'sd32767;
   localparam stream_pkg::prod_t SAT_MIN = -32'sd32768;

   stream_pkg::prod_t   product;
   stream_pkg::prod_t   shifted;
   stream_pkg::prod_t   biased;
   stream_pkg::sample_t saturated;
   stream_pkg::beat_t   beat_q;
   logic                valid_q;
   logic                in_fire;

   // Open when empty or when the held beat leaves this cycle
   // This is the combinational ready path the skid buffers isolate
   assign in_ready_o = ~valid_q | out_ready_i;
   assign in_fire    = in_valid_i & in_ready_o;

   assign out_valid_o = valid_q;
   assign out_beat_o  = beat_q;

   always_comb begin
      // Both operands are signed, so the product is sign extended to 32 bits
      product = in_beat_i.sample * gain_i;
      // Arithmetic shift drops the fraction bits of the gain
      shifted = product >>> FRAC_W;
      biased  = shifted + offset_i;
      // The sum cannot overflow 32 bits even with FRAC_W at 0
      if (biased > SAT_MAX) begin
         saturated = 16'sh7fff;
      end else if (biased < SAT_MIN) begin
         saturated = 16'sh8000;
      end else begin
         saturated = biased[15:0];
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else if (flush_i) begin
         valid_q <= 1'b0;
      end else if (in_fire) begin
         valid_q <= 1'b1;
      end else if (out_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   // Result and frame marker are captured together
   always_ff @(posedge clk_i) begin
      if (in_fire) begin
         beat_q.sample <= saturated;
         beat_q.last   <= in_beat_i.last;
      end
   end

endmodule

// ==== src/skid_buffer.sv ====
`timescale 1ns/1ps

// Two-entry skid buffer that cuts the ready path between its neighbours
// while still moving one beat per cycle
module skid_buffer #(
   parameter int unsigned DATA_W = 17
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              flush_i,

   input  logic              in_valid_i,
   output logic              in_ready_o,
   input  logic [DATA_W-1:0] in_data_i,

   output logic              out_valid_o,
   input  logic              out_ready_i,
   output logic [DATA_W-1:0] out_data_o
);

   // EXTRA means both registers hold a beat and the main one is on the output
   typedef enum logic [1:0] {
      SKID_EMPTY,
      SKID_DATA,
      SKID_EXTRA
   } skid_state_t;

   skid_state_t       state_q;
   skid_state_t       state_d;
   logic [DATA_W-1:0] main_q;
   logic [DATA_W-1:0] extra_q;
   logic              in_fire;
   logic              out_fire;
   logic              load_main;
   logic              load_extra;
   logic              main_from_extra;

   // Both handshake outputs come straight from the state register
   assign in_ready_o  = (state_q != SKID_EXTRA);
   assign out_valid_o = (state_q != SKID_EMPTY);
   assign out_data_o  = main_q;

   assign in_fire  = in_valid_i & in_ready_o;
   assign out_fire = out_valid_o & out_ready_i;

   always_comb begin
      state_d         = state_q;
      load_main       = 1'b0;
      load_extra      = 1'b0;
      main_from_extra = 1'b0;
      case (state_q)
         SKID_EMPTY: begin
            // Nothing is on the output, so only an input transfer can happen
            if (in_fire) begin
               state_d   = SKID_DATA;
               load_main = 1'b1;
            end
         end
         SKID_DATA: begin
            case ({in_fire, out_fire})
               2'b01: begin
                  state_d = SKID_EMPTY;
               end
               2'b10: begin
                  // The output stalled one cycle too late, park the new beat
                  state_d    = SKID_EXTRA;
                  load_extra = 1'b1;
               end
               2'b11: begin
                  load_main = 1'b1;
               end
               default: begin
                  state_d = SKID_DATA;
               end
            endcase
         end
         SKID_EXTRA: begin
            // Input is closed here and the parked beat moves up once the output drains
            if (out_fire) begin
               state_d         = SKID_DATA;
               main_from_extra = 1'b1;
            end
         end
         default: begin
            state_d = SKID_EMPTY;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= SKID_EMPTY;
      end else if (flush_i) begin
         state_q <= SKID_EMPTY;
      end else begin
         state_q <= state_d;
      end
   end

   // Payload registers are only qualified by the state
   always_ff @(posedge clk_i) begin
      if (load_main) begin
         main_q <= in_data_i;
      end else if (main_from_extra) begin
         main_q <= extra_q;
      end
      if (load_extra) begin
         extra_q <= in_data_i;
      end
   end

endmodule

// ==== src/stream_pipe_top.sv ====
`timescale 1ns/1ps

// Sample scaler pipeline: skid buffer, scaling stage, skid buffer and control
module stream_pipe_top #(
   parameter int unsigned FRAC_W = 8
) (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     flush_i,

   input  stream_pkg::gain_t        gain_i,
   input  stream_pkg::sample_t      offset_i,

   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   input  stream_pkg::beat_t        in_beat_i,

   output logic                     out_valid_o,
   input  logic                     out_ready_i,
   output stream_pkg::beat_t        out_beat_o,

   output logic                     busy_o,
   output stream_pkg::frame_count_t frame_count_o
);

   localparam int unsigned BEAT_W = $bits(stream_pkg::beat_t);

   logic              flush;
   logic              accept;
   logic              skid_in_ready;
   logic              mid_valid;
   logic              mid_ready;
   stream_pkg::beat_t mid_beat;
   logic              scaled_valid;
   logic              scaled_ready;
   stream_pkg::beat_t scaled_beat;

   // The control gate is registered, so the input ready stays free of downstream paths
   assign in_ready_o = skid_in_ready & accept;

   skid_buffer #(
      .DATA_W (BEAT_W)
   ) u_skid_in (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush),
      .in_valid_i  (in_valid_i & accept),
      .in_ready_o  (skid_in_ready),
      .in_data_i   (in_beat_i),
      .out_valid_o (mid_valid),
      .out_ready_i (mid_ready),
      .out_data_o  (mid_beat)
   );

   scale_stage #(
      .FRAC_W (FRAC_W)
   ) u_scale (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush),
      .gain_i      (gain_i),
      .offset_i    (offset_i),
      .in_valid_i  (mid_valid),
      .in_ready_o  (mid_ready),
      .in_beat_i   (mid_beat),
      .out_valid_o (scaled_valid),
      .out_ready_i (scaled_ready),
      .out_beat_o  (scaled_beat)
   );

   skid_buffer #(
      .DATA_W (BEAT_W)
   ) u_skid_out (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush),
      .in_valid_i  (scaled_valid),
      .in_ready_o  (scaled_ready),
      .in_data_i   (scaled_beat),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_data_o  (out_beat_o)
   );

   // Control only watches the transfers at the pipeline boundary
   pipe_ctrl u_ctrl (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .flush_i       (flush_i),
      .in_fire_i     (in_valid_i & in_ready_o),
      .out_fire_i    (out_valid_o & out_ready_i),
      .out_last_i    (out_beat_o.last),
      .flush_o       (flush),
      .accept_o      (accept),
      .busy_o        (busy_o),
      .frame_count_o (frame_count_o)
   );

endmodule

// ==== src/stream_pkg.sv ====
package stream_pkg;

   // Signed sample value as it travels through the pipeline
   typedef logic signed [15:0] sample_t;

   // Signed fixed-point gain, the fraction width is set by FRAC_W of the scaling stage
   typedef logic signed [15:0] gain_t;

   // Full-width product of a sample and a gain, wide enough to also hold the offset sum
   typedef logic signed [31:0] prod_t;

   // Number of frames delivered at the output
   typedef logic [15:0] frame_count_t;

   // One transfer on a stream link
   typedef struct packed {
      sample_t sample;
      // High on the final sample of a frame
      logic    last;
   } beat_t;

   // States of the control FSM in pipe_ctrl
   typedef enum logic [1:0] {
      CTRL_RUN,
      CTRL_FLUSH,
      CTRL_DRAIN
   } ctrl_state_t;

endpackage

// ==== verif/stream_pipe_props.sv ====
`timescale 1ns/1ps

// Concurrent checks on the pipeline boundary, bound into stream_pipe_top
module stream_pipe_props (
   input logic              clk_i,
   input logic              rst_i,
   input logic              flush_i,
   input logic              in_valid_i,
   input logic              in_ready_i,
   input logic              out_valid_i,
   input logic              out_ready_i,
   input stream_pkg::beat_t out_beat_i,
   input logic              busy_i
);

   // High from a flush pulse until the next transfer on either side
   logic idle_since_flush_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         idle_since_flush_q <= 1'b0;
      end else if (flush_i) begin
         idle_since_flush_q <= 1'b1;
      end else if ((in_valid_i && in_ready_i) || (out_valid_i && out_ready_i)) begin
         idle_since_flush_q <= 1'b0;
      end
   end

   // A stalled output beat must be held until it is taken, unless a flush drops it
   payload_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_i && !out_ready_i && !flush_i) |=> (out_valid_i && $stable(out_beat_i)))
      else $error("output beat changed or vanished while stalled");

   // The drain cycle after the flush pulse keeps the input closed
   ready_low_after_flush: assert property (@(posedge clk_i) disable iff (rst_i)
      flush_i |=> !in_ready_i)
      else $error("input ready high in the cycle after a flush pulse");

   idle_after_flush: assert property (@(posedge clk_i) disable iff (rst_i)
      idle_since_flush_q |-> !busy_i)
      else $error("busy high with an empty pipeline after a flush");

endmodule

// ==== verif/stream_pipe_tb.sv ====
`timescale 1ns/1ps

module stream_pipe_tb;

   localparam int unsigned FRAC_W    = 8;
   localparam int          NUM_TESTS = 5;
   localparam int          NUM_BEATS = 8;
   localparam int          TIMEOUT   = 200;
   localparam int          LATENCY   = 3;

   logic                     clk_i;
   logic                     rst_i;
   logic                     flush_i;
   stream_pkg::gain_t        gain_i;
   stream_pkg::sample_t      offset_i;
   logic                     in_valid_i;
   logic                     in_ready_o;
   stream_pkg::beat_t        in_beat_i;
   logic                     out_valid_o;
   logic                     out_ready_i;
   stream_pkg::beat_t        out_beat_o;
   logic                     busy_o;
   stream_pkg::frame_count_t frame_count_o;

   // Stimulus table, one row per test
   string                test_name    [NUM_TESTS];
   stream_pkg::gain_t    test_gain    [NUM_TESTS];
   stream_pkg::sample_t  test_offset  [NUM_TESTS];
   stream_pkg::sample_t  test_samples [NUM_TESTS][NUM_BEATS];
   // Bit i marks beat i as the end of a frame
   logic [NUM_BEATS-1:0] test_lasts   [NUM_TESTS];
   logic                 test_random  [NUM_TESTS];
   // Beat index before which a flush is issued or -1 when the test has no flush
   int                   test_flush_at[NUM_TESTS];

   stream_pkg::beat_t exp_q[$];
   int                cycle_q[$];
   stream_pkg::beat_t exp_beat;
   int                acc_cycle;
   int                cycle_count;
   string             cur_name;
   logic              random_ready;
   logic              check_latency;
   logic              aborted;
   logic [31:0]       lcg_state;
   int                test_errors;
   int                total_errors;
   int                tests_failed;
   int                beats_in;
   int                beats_out;
   int                frames_expected;

   stream_pipe_top #(
      .FRAC_W (FRAC_W)
   ) u_stream_pipe_top (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .flush_i       (flush_i),
      .gain_i        (gain_i),
      .offset_i      (offset_i),
      .in_valid_i    (in_valid_i),
      .in_ready_o    (in_ready_o),
      .in_beat_i     (in_beat_i),
      .out_valid_o   (out_valid_o),
      .out_ready_i   (out_ready_i),
      .out_beat_o    (out_beat_o),
      .busy_o        (busy_o),
      .frame_count_o (frame_count_o)
   );

   bind stream_pipe_top stream_pipe_props u_props (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .flush_i     (flush),
      .in_valid_i  (in_valid_i),
      .in_ready_i  (in_ready_o),
      .out_valid_i (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_beat_i  (out_beat_o),
      .busy_i      (busy_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Output ready for the next cycle which is random only in back-pressure tests
   function automatic logic draw_ready();
      if (!random_ready) begin
         return 1'b1;
      end
      lcg_state = lcg_next(lcg_state);
      return lcg_state[31];
   endfunction

   // Gain with FRAC_W fraction bits, floor shift, offset, then clip to 16 bits signed
   function automatic stream_pkg::beat_t scale_model(input stream_pkg::beat_t beat,
                                                     input stream_pkg::gain_t gain,
                                                     input stream_pkg::sample_t offset);
      longint            value;
      stream_pkg::beat_t result;
      value = longint'($signed(beat.sample)) * longint'(gain);
      value = (value >>> FRAC_W) + longint'(offset);
      if (value > 32767) begin
         value = 32767;
      end else if (value < -32768) begin
         value = -32768;
      end
      result.sample = stream_pkg::sample_t'(value);
      result.last   = beat.last;
      return result;
   endfunction

   function automatic void note_error();
      test_errors++;
      total_errors++;
   endfunction

   task automatic load_table();
      test_name[0]     = "unity";
      test_gain[0]     = stream_pkg::gain_t'(1 << FRAC_W);
      test_offset[0]   = 16'sd0;
      test_samples[0]  = '{16'sh0000, 16'sh0001, 16'shffff, 16'sd1234,
                           16'sd8000, -16'sd8000, 16'sh7fff, 16'sh8000};
      test_lasts[0]    = 8'b1000_0100;
      test_random[0]   = 1'b0;
      test_flush_at[0] = -1;
      // Gain of 3.0 drives the large samples into both clip limits
      test_name[1]     = "gain_clip";
      test_gain[1]     = 16'sh0300;
      test_offset[1]   = 16'sd100;
      test_samples[1]  = '{16'sd10000, -16'sd10000, 16'sd20000, -16'sd20000,
                           16'sd5, -16'sd5, 16'sh7fff, 16'sh8000};
      test_lasts[1]    = 8'b1000_0000;
      test_random[1]   = 1'b0;
      test_flush_at[1] = -1;
      test_name[2]     = "neg_gain";
      test_gain[2]     = 16'shff80;
      test_offset[2]   = -16'sd32000;
      test_samples[2]  = '{16'sh7fff, 16'sh8000, 16'sd100, -16'sd3,
                           16'sd2, -16'sd2, 16'sd1000, -16'sd1000};
      test_lasts[2]    = 8'b1000_1000;
      test_random[2]   = 1'b0;
      test_flush_at[2] = -1;
      test_name[3]     = "random_bp";
      test_gain[3]     = 16'sh0155;
      test_offset[3]   = 16'sd7;
      test_samples[3]  = '{16'sd12345, -16'sd321, 16'sd4000, -16'sd29000,
                           16'sd77, 16'sd30001, -16'sd1, 16'sd2048};
      test_lasts[3]    = 8'b1010_1010;
      test_random[3]   = 1'b1;
      test_flush_at[3] = -1;
      test_name[4]     = "flush";
      test_gain[4]     = 16'sh0100;
      test_offset[4]   = -16'sd5;
      test_samples[4]  = '{16'sd100, 16'sd200, 16'sd300, 16'sd400,
                           16'sd500, 16'sd600, 16'sd700, 16'sd800};
      test_lasts[4]    = 8'b1001_0010;
      test_random[4]   = 1'b1;
      test_flush_at[4] = 4;
   endtask

   // Both transfers are sampled on the rising edge with the output side handled first
   always @(posedge clk_i) begin
      if (!rst_i && out_valid_o && out_ready_i) begin
         assert (exp_q.size() > 0) else begin
            $display("test %s: output beat arrived with nothing pending", cur_name);
            note_error();
         end
         if (exp_q.size() > 0) begin
            exp_beat  = exp_q.pop_front();
            acc_cycle = cycle_q.pop_front();
            beats_out++;
            if (exp_beat.last) begin
               frames_expected++;
            end
            assert (out_beat_o == exp_beat) else begin
               $display("mismatch %s: expected %0d last %0b, actual %0d last %0b", cur_name,
                        $signed(exp_beat.sample), exp_beat.last,
                        $signed(out_beat_o.sample), out_beat_o.last);
               note_error();
            end
            if (check_latency) begin
               assert (cycle_count - acc_cycle == LATENCY) else begin
                  $display("mismatch %s latency: expected %0d, actual %0d", cur_name,
                           LATENCY, cycle_count - acc_cycle);
                  note_error();
               end
            end
         end
      end
      if (!rst_i && in_valid_i && in_ready_o) begin
         exp_q.push_back(scale_model(in_beat_i, gain_i, offset_i));
         cycle_q.push_back(cycle_count);
         beats_in++;
      end
      cycle_count++;
   end

   // Starts and ends on a falling edge and leaves the input open again
   task automatic flush_pipeline();
      in_valid_i  = 1'b0;
      out_ready_i = 1'b0;
      flush_i     = 1'b1;
      // Beats still inside are dropped by the flush and must never show up
      exp_q.delete();
      cycle_q.delete();
      @(negedge clk_i);
      flush_i = 1'b0;
      assert (!in_ready_o) else begin
         $display("test %s: input ready high in the flush cycle", cur_name);
         note_error();
      end
      @(negedge clk_i);
      assert (!in_ready_o) else begin
         $display("test %s: input ready high in the drain cycle", cur_name);
         note_error();
      end
      @(negedge clk_i);
      assert (in_ready_o && !busy_o && !out_valid_o) else begin
         $display("test %s: pipeline not empty and open after the flush", cur_name);
         note_error();
      end
      out_ready_i = draw_ready();
   endtask

   task automatic run_test(input int t);
      int   idx;
      int   stall;
      logic flushed;
      idx           = 0;
      stall         = 0;
      flushed       = 1'b0;
      cur_name      = test_name[t];
      test_errors   = 0;
      beats_in      = 0;
      beats_out     = 0;
      random_ready  = test_random[t];
      check_latency = !test_random[t] && (test_flush_at[t] < 0);
      gain_i        = test_gain[t];
      offset_i      = test_offset[t];
      while (idx < NUM_BEATS && !aborted) begin
         @(negedge clk_i);
         out_ready_i = draw_ready();
         if (idx == test_flush_at[t] && !flushed) begin
            flush_pipeline();
            flushed = 1'b1;
         end
         in_valid_i       = 1'b1;
         in_beat_i.sample = test_samples[t][idx];
         in_beat_i.last   = test_lasts[t][idx];
         // Input ready comes from registers, so its value now holds for the next edge
         if (in_ready_o) begin
            idx++;
            stall = 0;
         end else begin
            stall++;
            if (stall > TIMEOUT) begin
               $display("test %s: timeout waiting for input ready", cur_name);
               aborted = 1'b1;
            end
         end
      end
      @(negedge clk_i);
      in_valid_i  = 1'b0;
      out_ready_i = draw_ready();
      stall       = 0;
      // The last beat was taken on the edge just passed and is still inside
      if (!aborted) begin
         assert (busy_o) else begin
            $display("test %s: busy low with a beat just accepted", cur_name);
            note_error();
         end
      end
      while ((exp_q.size() != 0 || busy_o) && !aborted) begin
         @(negedge clk_i);
         out_ready_i = draw_ready();
         stall++;
         if (stall > TIMEOUT) begin
            $display("test %s: timeout while draining the pipeline", cur_name);
            aborted = 1'b1;
         end
      end
      assert (frame_count_o == stream_pkg::frame_count_t'(frames_expected)) else begin
         $display("mismatch %s frame count: expected %0d, actual %0d", cur_name,
                  frames_expected, frame_count_o);
         note_error();
      end
      if (test_errors != 0 || aborted) begin
         tests_failed++;
      end
      $display("test %-10s in %0d out %0d errors %0d", cur_name, beats_in, beats_out,
               test_errors);
   endtask

   initial begin
      rst_i           = 1'b1;
      flush_i         = 1'b0;
      gain_i          = '0;
      offset_i        = '0;
      in_valid_i      = 1'b0;
      in_beat_i       = '0;
      out_ready_i     = 1'b1;
      lcg_state       = 32'h9a1e8e10;
      cycle_count     = 0;
      cur_name        = "reset";
      random_ready    = 1'b0;
      check_latency   = 1'b0;
      aborted         = 1'b0;
      test_errors     = 0;
      total_errors    = 0;
      tests_failed    = 0;
      beats_in        = 0;
      beats_out       = 0;
      frames_expected = 0;
      load_table();
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      assert (!out_valid_o && !busy_o && !u_stream_pipe_top.u_ctrl.flush_o &&
              frame_count_o == '0 && in_ready_o) else begin
         $display("reset: outputs are not at their reset values");
         note_error();
      end
      for (int t = 0; t < NUM_TESTS; t++) begin
         if (!aborted) begin
            run_test(t);
         end
      end
      $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, total_errors);
      if (total_errors == 0 && !aborted) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
